// ==== mips_pkg.sv ====
package mips_pkg;

    // Data path width
    localparam int XLEN = 32;

    // Register index width, 32 architectural registers
    localparam int REG_ADDR_W = 5;

    // Instruction field widths
    localparam int OPCODE_W = 6;
    localparam int FUNCT_W = 6;
    localparam int SHAMT_W = 5;
    localparam int IMM_W = 16;
    localparam int TARGET_W = 26;

    // First fetch address after reset (kseg1 boot ROM)
    localparam logic [XLEN-1:0] RESET_VECTOR = 32'hBFC00000;

    // Supported operations
    typedef enum logic [4:0] {
        // R-type arithmetic and logic
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        // I-type arithmetic and logic
        OP_ADDIU,
        OP_ANDI,
        OP_ORI,
        OP_XORI,
        OP_LUI,
        // Word loads and stores
        OP_LW,
        OP_SW,
        // Control flow
        OP_BEQ,
        OP_BNE,
        OP_J,
        OP_JR,
        // Anything not decoded, executed as a no-op
        OP_INVALID
    } mips_op_t;

    // Sequencer phases
    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM,
        ST_HALT
    } mips_state_t;

endpackage

// ==== mips_decoded_if.sv ====
`timescale 1ns/1ps

interface mips_decoded_if;
    import mips_pkg::*;

    // Decoded operation
    mips_op_t op;

    // Register indices
    logic [REG_ADDR_W-1:0] rs_index;
    logic [REG_ADDR_W-1:0] rt_index;
    logic [REG_ADDR_W-1:0] dest_index;

    // Extended immediate, shift amount and jump destination
    logic [XLEN-1:0] imm_ext;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0] jump_target;

    modport source(output op, rs_index, rt_index, dest_index, imm_ext, shamt, jump_target);

    modport alu_sink(input op, imm_ext, shamt);

    modport seq_sink(input op, dest_index, imm_ext, jump_target);

endinterface

// ==== mips_decode.sv ====
`timescale 1ns/1ps

module mips_decode (
    input  logic [mips_pkg::XLEN-1:0] instruction,
    input  logic [mips_pkg::XLEN-1:0] pc,
    mips_decoded_if.source dec
);
    import mips_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT_W-1:0] funct;
    logic [IMM_W-1:0] imm;
    logic [TARGET_W-1:0] target;
    logic [XLEN-1:0] pc_plus4;
    logic zero_ext;
    mips_op_t op;

    // Raw instruction fields
    assign opcode = instruction[31:26];
    assign funct = instruction[5:0];
    assign imm = instruction[15:0];
    assign target = instruction[25:0];

    // Jump region comes from the following instruction address
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        op = OP_INVALID;
        case (opcode)
            // SPECIAL group, selected by funct
            6'h00: begin
                case (funct)
                    6'h00: op = OP_SLL;
                    6'h02: op = OP_SRL;
                    6'h08: op = OP_JR;
                    6'h21: op = OP_ADDU;
                    6'h23: op = OP_SUBU;
                    6'h24: op = OP_AND;
                    6'h25: op = OP_OR;
                    6'h26: op = OP_XOR;
                    6'h2A: op = OP_SLT;
                    6'h2B: op = OP_SLTU;
                    default: op = OP_INVALID;
                endcase
            end
            6'h02: op = OP_J;
            6'h04: op = OP_BEQ;
            6'h05: op = OP_BNE;
            6'h09: op = OP_ADDIU;
            6'h0C: op = OP_ANDI;
            6'h0D: op = OP_ORI;
            6'h0E: op = OP_XORI;
            6'h0F: op = OP_LUI;
            6'h23: op = OP_LW;
            6'h2B: op = OP_SW;
            default: op = OP_INVALID;
        endcase
    end

    // Logical immediates zero extend
    assign zero_ext = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);

    assign dec.op = op;
    assign dec.rs_index = instruction[25:21];
    assign dec.rt_index = instruction[20:16];

    // R-type writes rd, I-type writes rt
    assign dec.dest_index = (opcode == '0) ? instruction[15:11] : instruction[20:16];

    assign dec.imm_ext = zero_ext ? {{(XLEN-IMM_W){1'b0}}, imm}
                                  : {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm};
    assign dec.shamt = instruction[10:6];

    // 256 MB region of PC+4, word index shifted up by two
    assign dec.jump_target = {pc_plus4[XLEN-1:XLEN-4], target, 2'b00};

endmodule

// ==== mips_regfile.sv ====
`timescale 1ns/1ps

module mips_regfile (
    input  logic clk,
    input  logic reset,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rs_index,
    input  logic [mips_pkg::REG_ADDR_W-1:0] rt_index,
    input  logic write_enable,
    input  logic [mips_pkg::REG_ADDR_W-1:0] write_index,
    input  logic [mips_pkg::XLEN-1:0] write_data,
    output logic [mips_pkg::XLEN-1:0] rs_data,
    output logic [mips_pkg::XLEN-1:0] rt_data,
    output logic [mips_pkg::XLEN-1:0] v0
);
    import mips_pkg::*;

    // Architectural registers
    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '{default: '0};
        end else if (write_enable && (write_index != '0)) begin
            // Register zero never written, so it reads back zero
            regs[write_index] <= write_data;
        end
    end

    // Two asynchronous read ports
    assign rs_data = regs[rs_index];
    assign rt_data = regs[rt_index];

    // Result register tap
    assign v0 = regs[2];

endmodule

// ==== mips_alu.sv ====
`timescale 1ns/1ps

module mips_alu (
    mips_decoded_if.alu_sink dec,
    input  logic [mips_pkg::XLEN-1:0] rs_data,
    input  logic [mips_pkg::XLEN-1:0] rt_data,
    output logic [mips_pkg::XLEN-1:0] result,
    output logic branch_taken
);
    import mips_pkg::*;

    logic lt_signed;
    logic lt_unsigned;

    // Compare results for slt and sltu
    assign lt_signed = $signed(rs_data) < $signed(rt_data);
    assign lt_unsigned = rs_data < rt_data;

    always_comb begin
        case (dec.op)
            // Register-register
            OP_ADDU: result = rs_data + rt_data;
            OP_SUBU: result = rs_data - rt_data;
            OP_AND: result = rs_data & rt_data;
            OP_OR: result = rs_data | rt_data;
            OP_XOR: result = rs_data ^ rt_data;
            OP_SLT: result = {{(XLEN-1){1'b0}}, lt_signed};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            // Shifts act on rt by the fixed amount
            OP_SLL: result = rt_data << dec.shamt;
            OP_SRL: result = rt_data >> dec.shamt;
            // Register-immediate
            OP_ADDIU: result = rs_data + dec.imm_ext;
            OP_ANDI: result = rs_data & dec.imm_ext;
            OP_ORI: result = rs_data | dec.imm_ext;
            OP_XORI: result = rs_data ^ dec.imm_ext;
            // Immediate into the upper half
            OP_LUI: result = {dec.imm_ext[IMM_W-1:0], {(XLEN-IMM_W){1'b0}}};
            // Effective address, base plus signed offset
            OP_LW,
            OP_SW: result = rs_data + dec.imm_ext;
            default: result = '0;
        endcase
    end

    // Branch decision
    always_comb begin
        case (dec.op)
            OP_BEQ: branch_taken = (rs_data == rt_data);
            OP_BNE: branch_taken = (rs_data != rt_data);
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== mips_sequencer.sv ====
`timescale 1ns/1ps

module mips_sequencer #(
    parameter logic [mips_pkg::XLEN-1:0] RESET_PC = mips_pkg::RESET_VECTOR
) (
    input  logic clk,
    input  logic reset,
    mips_decoded_if.seq_sink dec,
    input  logic [mips_pkg::XLEN-1:0] rs_data,
    input  logic [mips_pkg::XLEN-1:0] rt_data,
    input  logic [mips_pkg::XLEN-1:0] alu_result,
    input  logic branch_taken,
    input  logic waitrequest,
    input  logic [mips_pkg::XLEN-1:0] readdata,
    output logic [mips_pkg::XLEN-1:0] instruction,
    output logic [mips_pkg::XLEN-1:0] pc,
    output logic write_enable,
    output logic [mips_pkg::REG_ADDR_W-1:0] write_index,
    output logic [mips_pkg::XLEN-1:0] write_data,
    output logic [mips_pkg::XLEN-1:0] address,
    output logic read,
    output logic write,
    output logic [mips_pkg::XLEN-1:0] writedata,
    output logic [3:0] byteenable,
    output logic active
);
    import mips_pkg::*;

    mips_state_t state;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic is_alu_op;
    logic is_mem_op;

    assign pc_plus4 = pc + 32'd4;
    assign is_alu_op = dec.op inside {OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_SLT,
                                      OP_SLTU, OP_SLL, OP_SRL, OP_ADDIU, OP_ANDI,
                                      OP_ORI, OP_XORI, OP_LUI};
    assign is_mem_op = (dec.op == OP_LW) || (dec.op == OP_SW);

    // No delay slot, so the target is fetched right after
    always_comb begin
        next_pc = pc_plus4;
        if (branch_taken) begin
            next_pc = pc_plus4 + {dec.imm_ext[XLEN-3:0], 2'b00};
        end else if (dec.op == OP_J) begin
            next_pc = dec.jump_target;
        end else if (dec.op == OP_JR) begin
            next_pc = rs_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
            pc <= RESET_PC;
            instruction <= '0;
        end else begin
            case (state)
                ST_FETCH: begin
                    // Hold until the bus accepts, latch the word
                    if (!waitrequest) begin
                        instruction <= readdata;
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    pc <= next_pc;
                    if (is_mem_op) begin
                        state <= ST_MEM;
                    end else if ((dec.op == OP_JR) && (rs_data == '0)) begin
                        state <= ST_HALT;
                    end else begin
                        state <= ST_FETCH;
                    end
                end
                ST_MEM: begin
                    if (!waitrequest) begin
                        state <= ST_FETCH;
                    end
                end
                default: state <= ST_HALT;
            endcase
        end
    end

    // Write-back from ALU in execute, from bus on load completion
    assign write_enable = ((state == ST_EXEC) && is_alu_op) ||
                          ((state == ST_MEM) && (dec.op == OP_LW) && !waitrequest);
    assign write_index = dec.dest_index;
    assign write_data = (state == ST_MEM) ? readdata : alu_result;

    // Bus master, IR and registers stay put while stalled
    assign address = (state == ST_MEM) ? alu_result : pc;
    assign read = (state == ST_FETCH) || ((state == ST_MEM) && (dec.op == OP_LW));
    assign write = (state == ST_MEM) && (dec.op == OP_SW);
    assign writedata = rt_data;
    assign byteenable = 4'b1111;
    assign active = (state != ST_HALT);

endmodule

// ==== mips_cpu_bus.sv ====
`timescale 1ns/1ps

module mips_cpu_bus #(
    parameter logic [31:0] RESET_PC = mips_pkg::RESET_VECTOR
) (
    input  logic clk,
    input  logic reset,
    output logic active,
    output logic [31:0] register_v0,

    // Memory bus
    input  logic waitrequest,
    input  logic [31:0] readdata,
    output logic [31:0] address,
    output logic read,
    output logic write,
    output logic [31:0] writedata,
    output logic [3:0] byteenable
);
    import mips_pkg::*;

    // Fetched word and its address
    logic [XLEN-1:0] instruction;
    logic [XLEN-1:0] pc;

    // Register read data
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;

    // ALU outputs
    logic [XLEN-1:0] alu_result;
    logic branch_taken;

    // Write-back port
    logic write_enable;
    logic [REG_ADDR_W-1:0] write_index;
    logic [XLEN-1:0] write_data;

    mips_decoded_if dec_if ();

    mips_decode u_decode (
        .instruction(instruction),
        .pc(pc),
        .dec(dec_if)
    );

    mips_regfile u_regfile (
        .clk(clk),
        .reset(reset),
        .rs_index(dec_if.rs_index),
        .rt_index(dec_if.rt_index),
        .write_enable(write_enable),
        .write_index(write_index),
        .write_data(write_data),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .v0(register_v0)
    );

    mips_alu u_alu (
        .dec(dec_if),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .result(alu_result),
        .branch_taken(branch_taken)
    );

    mips_sequencer #(
        .RESET_PC(RESET_PC)
    ) u_sequencer (
        .clk(clk),
        .reset(reset),
        .dec(dec_if),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .alu_result(alu_result),
        .branch_taken(branch_taken),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .instruction(instruction),
        .pc(pc),
        .write_enable(write_enable),
        .write_index(write_index),
        .write_data(write_data),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable),
        .active(active)
    );

endmodule

// ==== tb_mips_checker.sv ====
`timescale 1ns/1ps

module tb_mips_checker #(
    parameter int PROG_LEN = 200,
    parameter int DATA_WORDS = 256,
    parameter logic [31:0] RESET_PC = mips_pkg::RESET_VECTOR,
    parameter logic [31:0] DATA_BASE = 32'h00001000
) (
    input  logic clk,
    input  logic reset,
    input  logic active,
    input  logic [31:0] register_v0,
    input  logic [31:0] address,
    input  logic read,
    input  logic write,
    input  logic [31:0] writedata,
    input  logic [3:0] byteenable,
    input  logic waitrequest,
    input  logic [31:0] prog_img [PROG_LEN],
    input  logic [31:0] data_img [DATA_WORDS],
    output int error_count
);
    // Kind of transfer the model waits for next
    localparam logic [1:0] EXP_FETCH = 2'd0;
    localparam logic [1:0] EXP_LOAD = 2'd1;
    localparam logic [1:0] EXP_STORE = 2'd2;

    // Architectural state of the model
    logic [31:0] regs [32];
    logic [31:0] dmem [DATA_WORDS];
    logic [31:0] pc_m;
    logic [1:0] expect_kind;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [4:0] load_dest;
    logic v0_pending;
    logic model_halted;
    logic halt_seen;

    // Bus as seen one cycle back
    logic prev_reset;
    logic prev_stalled;
    logic [31:0] prev_address;
    logic [31:0] prev_writedata;
    logic prev_read;
    logic prev_write;

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
        error_count++;
    endtask

    task automatic report_text(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        error_count++;
    endtask

    // Word slot of an address within a region
    // Addresses below the base wrap to a huge slot
    function automatic int word_index(input logic [31:0] addr, input logic [31:0] base);
        return int'((addr - base) >> 2);
    endfunction

    task automatic write_reg(input logic [4:0] idx, input logic [31:0] value);
        if (idx != 5'd0) begin
            regs[idx] = value;
        end
        // v0 compared once the core has written it back
        if (idx == 5'd2) begin
            v0_pending = 1'b1;
        end
    endtask

    // One instruction per ISA rules without a delay slot
    task automatic execute_model(input logic [31:0] instr);
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] npc;
        rs = instr[25:21];
        rt = instr[20:16];
        rd = instr[15:11];
        a = regs[rs];
        b = regs[rt];
        simm = {{16{instr[15]}}, instr[15:0]};
        zimm = {16'h0000, instr[15:0]};
        npc = pc_m + 32'd4;
        case (instr[31:26])
            6'h00: begin
                case (instr[5:0])
                    6'h00: write_reg(rd, b << instr[10:6]);
                    6'h02: write_reg(rd, b >> instr[10:6]);
                    6'h08: begin
                        npc = a;
                        model_halted = (a == 32'd0);
                    end
                    6'h21: write_reg(rd, a + b);
                    6'h23: write_reg(rd, a - b);
                    6'h24: write_reg(rd, a & b);
                    6'h25: write_reg(rd, a | b);
                    6'h26: write_reg(rd, a ^ b);
                    6'h2A: write_reg(rd, {31'd0, ($signed(a) < $signed(b))});
                    6'h2B: write_reg(rd, {31'd0, (a < b)});
                    default: ;
                endcase
            end
            6'h02: npc = {npc[31:28], instr[25:0], 2'b00};
            6'h04: if (a == b) npc = npc + (simm << 2);
            6'h05: if (a != b) npc = npc + (simm << 2);
            6'h09: write_reg(rt, a + simm);
            6'h0C: write_reg(rt, a & zimm);
            6'h0D: write_reg(rt, a | zimm);
            6'h0E: write_reg(rt, a ^ zimm);
            6'h0F: write_reg(rt, {instr[15:0], 16'h0000});
            6'h23: begin
                expect_kind = EXP_LOAD;
                exp_addr = a + simm;
                load_dest = rt;
            end
            6'h2B: begin
                expect_kind = EXP_STORE;
                exp_addr = a + simm;
                exp_wdata = b;
            end
            default: ;
        endcase
        pc_m = npc;
    endtask

    // Sort a completed transfer against what the model expects
    task automatic handle_transfer();
        int idx;
        if (expect_kind == EXP_FETCH) begin
            if (!read) begin
                report_text("write completed where an instruction fetch was expected");
            end else begin
                if (address !== pc_m) report_value("fetch address", pc_m, address);
                if (v0_pending && (register_v0 !== regs[2])) begin
                    report_value("register_v0", regs[2], register_v0);
                end
                v0_pending = 1'b0;
                idx = word_index(pc_m, RESET_PC);
                if (idx < PROG_LEN) begin
                    execute_model(prog_img[idx]);
                end else begin
                    report_text("model PC left the program image");
                end
            end
        end else begin
            idx = word_index(exp_addr, DATA_BASE);
            if (idx >= DATA_WORDS) begin
                report_text("data access outside the data region");
            end else if (expect_kind == EXP_LOAD) begin
                if (!read) report_text("write completed where a load was expected");
                if (address !== exp_addr) report_value("load address", exp_addr, address);
                write_reg(load_dest, dmem[idx]);
            end else begin
                if (!write) report_text("read completed where a store was expected");
                if (address !== exp_addr) report_value("store address", exp_addr, address);
                if (writedata !== exp_wdata) report_value("writedata", exp_wdata, writedata);
                dmem[idx] = exp_wdata;
            end
            expect_kind = EXP_FETCH;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) regs[i] = '0;
            for (int i = 0; i < DATA_WORDS; i++) dmem[i] = data_img[i];
            pc_m = RESET_PC;
            expect_kind = EXP_FETCH;
            v0_pending = 1'b0;
            model_halted = 1'b0;
            halt_seen = 1'b0;
            prev_stalled = 1'b0;
            error_count = 0;
        end else begin
            // First cycle out of reset
            if (prev_reset) begin
                if (active !== 1'b1) report_value("active", 32'd1, {31'd0, active});
                if (read !== 1'b1) report_value("read", 32'd1, {31'd0, read});
                if (write !== 1'b0) report_value("write", 32'd0, {31'd0, write});
                if (address !== RESET_PC) report_value("address", RESET_PC, address);
            end
            if (read && write) report_text("read and write high in the same cycle");
            // Request held steady through a stall
            if (prev_stalled) begin
                if (address !== prev_address) report_value("address", prev_address, address);
                if (writedata !== prev_writedata) begin
                    report_value("writedata", prev_writedata, writedata);
                end
                if (read !== prev_read) report_value("read", {31'd0, prev_read}, {31'd0, read});
                if (write !== prev_write) begin
                    report_value("write", {31'd0, prev_write}, {31'd0, write});
                end
            end
            if ((read || write) && (byteenable !== 4'b1111)) begin
                report_value("byteenable", 32'h0000000F, {28'd0, byteenable});
            end
            if (model_halted && (read || write)) begin
                report_text("bus request after the core executed jr to zero");
            end else if ((read || write) && !waitrequest) begin
                handle_transfer();
            end
            // Halt and final v0
            if (!active) begin
                if (!halt_seen) begin
                    halt_seen = 1'b1;
                    if (!model_halted) begin
                        report_text("core stopped before the program reached jr to zero");
                    end else if (register_v0 !== regs[2]) begin
                        report_value("register_v0", regs[2], register_v0);
                    end
                end
            end else if (halt_seen) begin
                report_text("active rose again after halt");
            end
        end
        prev_reset = reset;
        prev_stalled = (read || write) && waitrequest && !reset;
        prev_address = address;
        prev_writedata = writedata;
        prev_read = read;
        prev_write = write;
    end

endmodule

// ==== tb_mips_cpu_bus.sv ====
`timescale 1ns/1ps

module tb_mips_cpu_bus;
    import mips_pkg::*;

    localparam int PROG_LEN = 200;
    localparam int FIRST_TAIL = PROG_LEN - 3;
    localparam int DATA_WORDS = 256;
    localparam int WAIT_LEN = 1024;
    localparam int TIMEOUT_CYCLES = PROG_LEN * 40;
    localparam logic [31:0] DATA_BASE = 32'h00001000;
    localparam logic [4:0] BASE_REG = 5'd8;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic waitrequest = 1'b1;
    logic [31:0] readdata = 32'd0;
    logic active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic read;
    logic write;
    logic [31:0] writedata;
    logic [3:0] byteenable;

    // Program image, initial and live data, stall pattern
    logic [31:0] prog_mem [PROG_LEN];
    logic [31:0] data_init [DATA_WORDS];
    logic [31:0] data_mem [DATA_WORDS];
    logic wait_pattern [WAIT_LEN];
    integer seed;
    int cycle;
    int error_count;

    always #10 clk = ~clk;

    mips_cpu_bus #(
        .RESET_PC(RESET_VECTOR)
    ) DUT (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable)
    );

    tb_mips_checker #(
        .PROG_LEN(PROG_LEN),
        .DATA_WORDS(DATA_WORDS),
        .RESET_PC(RESET_VECTOR),
        .DATA_BASE(DATA_BASE)
    ) u_checker (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable),
        .waitrequest(waitrequest),
        .prog_img(prog_mem),
        .data_img(data_init),
        .error_count(error_count)
    );

    function automatic logic [31:0] encode_rtype(input logic [4:0] rs, input logic [4:0] rt,
                                                 input logic [4:0] rd, input logic [4:0] sh,
                                                 input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
                                                 input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_instruction(input int index);
        logic [31:0] r;
        logic [31:0] q;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [5:0] code;
        logic [31:0] target;
        int room;
        int skip;
        r = $random(seed);
        q = $random(seed);
        rs = {1'b0, r[3:0]};
        rt = {1'b0, r[7:4]};
        // Leftover picks of zero or the base pointer go to v0
        rd = {1'b0, r[11:8]};
        if ((rd == 5'd0) || (rd == BASE_REG)) rd = 5'd2;
        // Forward skips stay inside the body or land on the tail
        room = FIRST_TAIL - index - 1;
        skip = 1 + int'(q[17:16]) % 3;
        if (skip > room) skip = room;
        case (r[31:28])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                case (r[26:24])
                    3'd0: code = 6'h21;
                    3'd1: code = 6'h23;
                    3'd2: code = 6'h24;
                    3'd3: code = 6'h25;
                    3'd4: code = 6'h26;
                    3'd5: code = 6'h2A;
                    default: code = 6'h2B;
                endcase
                return encode_rtype(rs, rt, rd, 5'd0, code);
            end
            4'd5: return encode_rtype(5'd0, rt, rd, q[4:0], r[27] ? 6'h02 : 6'h00);
            4'd6, 4'd7, 4'd8: begin
                case (r[27:26])
                    2'd0: code = 6'h09;
                    2'd1: code = 6'h0C;
                    2'd2: code = 6'h0D;
                    default: code = 6'h0E;
                endcase
                return encode_itype(code, rs, rd, q[15:0]);
            end
            4'd9: return encode_itype(6'h0F, 5'd0, rd, q[15:0]);
            4'd10, 4'd11: return encode_itype(6'h23, BASE_REG, rd, {6'd0, q[7:0], 2'b00});
            4'd12: return encode_itype(6'h2B, BASE_REG, rt, {6'd0, q[7:0], 2'b00});
            4'd13, 4'd14: begin
                if (room < 1) return encode_itype(6'h09, rs, rd, q[15:0]);
                // Same register twice makes beq taken
                if (r[27]) rt = rs;
                return encode_itype(r[28] ? 6'h05 : 6'h04, rs, rt, 16'(skip));
            end
            default: begin
                if (room < 1) return encode_itype(6'h09, rs, rd, q[15:0]);
                target = RESET_VECTOR + 32'(4 * (index + 1 + skip));
                return {6'h02, target[27:2]};
            end
        endcase
    endfunction

    // Unmapped words return a pattern of the full address
    function automatic logic [31:0] read_word(input logic [31:0] addr);
        int idx;
        idx = int'((addr - RESET_VECTOR) >> 2);
        if (idx < PROG_LEN) return prog_mem[idx];
        idx = int'((addr - DATA_BASE) >> 2);
        if (idx < DATA_WORDS) return data_mem[idx];
        return addr ^ 32'hDEADBEEF;
    endfunction

    // Slave answers only after it has seen the request for a cycle
    always @(posedge clk) begin
        int idx;
        if (reset) begin
            for (int i = 0; i < DATA_WORDS; i++) data_mem[i] <= data_init[i];
            waitrequest <= 1'b1;
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
            if ((read || write) && !waitrequest) begin
                idx = int'((address - DATA_BASE) >> 2);
                if (write && (idx < DATA_WORDS)) data_mem[idx] <= writedata;
                waitrequest <= 1'b1;
            end else if ((read || write) && !wait_pattern[cycle % WAIT_LEN]) begin
                waitrequest <= 1'b0;
                readdata <= read ? read_word(address) : 32'd0;
            end else begin
                waitrequest <= 1'b1;
            end
        end
    end

    initial begin
        logic [31:0] draw;
        seed = 32'h96d2c07b;
        for (int i = 0; i < DATA_WORDS; i++) data_init[i] = $random(seed);
        // About 40 percent stall cycles
        for (int i = 0; i < WAIT_LEN; i++) begin
            draw = $random(seed);
            wait_pattern[i] = (draw[7:0] < 8'd102);
        end
        // Base pointer to the data region
        prog_mem[0] = encode_itype(6'h0F, 5'd0, BASE_REG, DATA_BASE[31:16]);
        prog_mem[1] = encode_itype(6'h0D, BASE_REG, BASE_REG, DATA_BASE[15:0]);
        for (int i = 2; i < FIRST_TAIL; i++) prog_mem[i] = random_instruction(i);
        // Tail stores t1, reads it back into v0 and halts
        prog_mem[FIRST_TAIL] = encode_itype(6'h2B, BASE_REG, 5'd9, 16'h0000);
        prog_mem[FIRST_TAIL + 1] = encode_itype(6'h23, BASE_REG, 5'd2, 16'h0000);
        prog_mem[FIRST_TAIL + 2] = encode_rtype(5'd0, 5'd0, 5'd0, 5'd0, 6'h08);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        wait (!active);
        repeat (4) @(posedge clk);
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (16 + TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the core did not halt within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d", error_count);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== all.f ====
mips_pkg.sv
mips_decoded_if.sv
mips_decode.sv
mips_regfile.sv
mips_alu.sv
mips_sequencer.sv
mips_cpu_bus.sv
tb_mips_checker.sv
tb_mips_cpu_bus.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing
TOP ?= tb_mips_cpu_bus
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
